// File: Bender.yml
package:
  name: msx_config_loader

sources:
  - include_dirs:
      - logic
    files:
      - logic/ddr_rd_pkg.sv
      - logic/msx_cfg_pkg.sv
      - logic/ddr_rd_if.sv
      - logic/download_watch.sv
      - logic/config_parser.sv
      - logic/msx_config_loader.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_ddr_model.sv
      - test/loader_checker.sv
      - test/tb_msx_config_loader.sv

// File: logic/config_parser.sv
`timescale 1ns/1ns
`default_nettype none

`include "msx_cfg_macros.svh"

module config_parser (
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  wire logic                 start,
   input  wire ddr_rd_pkg::dl_addr_t length,
   ddr_rd_if.reader                  mem,
   input  wire logic                 update_ack,
   output logic                      update_request,
   output msx_cfg_pkg::msx_type_t    msx_type,
   output msx_cfg_pkg::msx_config_t  msx_config [`MSX_MAX_CONFIG]
);

   typedef enum logic [2:0] {
      ST_SLEEP,
      ST_PARSE,
      ST_PARSE_BLOCK,
      ST_BLOCK_NONE,
      ST_PARSE_NEXT
   } state_t;

   localparam int CNT_W = $clog2(`MSX_MAX_CONFIG);
   localparam logic [CNT_W-1:0] LAST_ENTRY = CNT_W'(`MSX_MAX_CONFIG - 1);
   localparam logic [3:0] LAST_BYTE = 4'd7;   // Header bytes past 7 are not used

   state_t                   state;
   logic [CNT_W-1:0]         cfg_idx;
   logic [3:0]               head_idx;
   logic [3:0]               next_idx;
   ddr_rd_pkg::img_offset_t  offset;
   ddr_rd_pkg::img_offset_t  blk_span;
   ddr_rd_pkg::dl_addr_t     img_len;
   logic                     rd;
   logic                     byte_valid;
   logic                     past_end;
   logic                     magic_bad;
   msx_cfg_pkg::msx_config_t cur;

   // Image starts at DDR3 address 0
   assign mem.rd      = rd;
   assign mem.request = state != ST_SLEEP;
   assign mem.addr    = ddr_rd_pkg::ddr_addr_t'(offset) + ddr_rd_pkg::ddr_addr_t'(head_idx);

   // Byte is back and the port is free for the next read
   assign byte_valid = mem.ready & ~rd;

   // Index of the next header byte to fetch
   assign next_idx = (state == ST_PARSE) ? 4'd0 : head_idx + 4'd1;
   assign past_end = (ddr_rd_pkg::dl_addr_t'(offset) + ddr_rd_pkg::dl_addr_t'(next_idx))
                     > img_len;

   assign cur      = msx_config[cfg_idx];
   assign blk_span = (cur.typ == msx_cfg_pkg::CONFIG_RAM) ? '0 :
                     ddr_rd_pkg::img_offset_t'(cur.block_count) << `MSX_BLOCK_SHIFT;

   always_comb begin
      case (head_idx)
         4'd0:    magic_bad = mem.dout != "M";
         4'd1:    magic_bad = mem.dout != "S";
         4'd2:    magic_bad = mem.dout != "X";
         default: magic_bad = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == ST_SLEEP && start) begin
         img_len <= length;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state          <= ST_SLEEP;
         rd             <= 1'b0;
         update_request <= 1'b0;
         msx_type       <= '0;
         cfg_idx        <= '0;
         head_idx       <= '0;
         offset         <= '0;
         for (int i = 0; i < `MSX_MAX_CONFIG; i++) begin
            msx_config[i] <= '0;   // Typ is CONFIG_NONE
         end
      end else begin
         if (mem.ready) rd <= 1'b0;   // Read accepted
         if (update_ack) update_request <= 1'b0;
         case (state)
            ST_SLEEP: begin
               if (start) begin
                  cfg_idx <= '0;
                  offset  <= '0;
                  state   <= ST_PARSE;
               end
            end
            ST_PARSE: begin
               if (byte_valid) begin
                  head_idx <= '0;
                  if (past_end) begin
                     state <= ST_BLOCK_NONE;
                  end else begin
                     rd    <= 1'b1;
                     state <= ST_PARSE_BLOCK;
                  end
               end
            end
            ST_PARSE_BLOCK: begin
               if (byte_valid) begin
                  case (head_idx)
                     4'd3: if (cfg_idx == '0) msx_type <= mem.dout[1:0];
                     4'd4: msx_config[cfg_idx].typ <= msx_cfg_pkg::config_typ_t'(mem.dout);
                     4'd5: msx_config[cfg_idx].block_id <= mem.dout[3:0];
                     4'd6: msx_config[cfg_idx].block_count <= mem.dout;
                     4'd7: begin
                        msx_config[cfg_idx].slot                 <= mem.dout[6:5];
                        msx_config[cfg_idx].slot_internal_mapper <= mem.dout[4];
                        msx_config[cfg_idx].sub_slot             <= mem.dout[3:2];
                        msx_config[cfg_idx].start_block          <= mem.dout[1:0];
                        msx_config[cfg_idx].store_address        <=
                           ddr_rd_pkg::ddr_addr_t'(offset) + `MSX_HEADER_BYTES;
                     end
                     default: ;
                  endcase
                  if (magic_bad) begin
                     state <= ST_BLOCK_NONE;
                  end else if (head_idx == LAST_BYTE) begin
                     offset <= offset + `MSX_HEADER_BYTES + blk_span;   // Next header
                     state  <= ST_PARSE_NEXT;
                  end else if (past_end) begin
                     state <= ST_BLOCK_NONE;   // Image ends inside the header
                  end else begin
                     head_idx <= next_idx;
                     rd       <= 1'b1;
                  end
               end
            end
            ST_BLOCK_NONE: begin
               msx_config[cfg_idx].typ <= msx_cfg_pkg::CONFIG_NONE;
               state                   <= ST_PARSE_NEXT;
            end
            ST_PARSE_NEXT: begin
               if (cfg_idx == LAST_ENTRY) begin
                  update_request <= 1'b1;
                  state          <= ST_SLEEP;
               end else begin
                  cfg_idx <= cfg_idx + 1'b1;
                  state   <= ST_PARSE;
               end
            end
            default: state <= ST_SLEEP;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/ddr_rd_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ddr_rd_if;

   logic                  ready;
   logic                  rd;
   ddr_rd_pkg::ddr_byte_t dout;
   ddr_rd_pkg::ddr_addr_t addr;
   logic                  request;   // Parser owns the port

   modport reader (
      input  ready,
      input  dout,
      output rd,
      output addr,
      output request
   );

   modport port (
      output ready,
      output dout,
      input  rd,
      input  addr,
      input  request
   );

endinterface

`default_nettype wire

// File: logic/ddr_rd_pkg.sv
`default_nettype none

package ddr_rd_pkg;

   typedef logic [27:0] ddr_addr_t;    // DDR3 byte address
   typedef logic  [7:0] ddr_byte_t;

   typedef logic [26:0] dl_addr_t;     // Host download address
   typedef logic [15:0] dl_index_t;

   typedef logic [23:0] img_offset_t;  // Offset of a block inside the image

endpackage

`default_nettype wire

// File: logic/download_watch.sv
`timescale 1ns/1ns
`default_nettype none

`include "msx_cfg_macros.svh"

module download_watch (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire logic                  download,
   input  wire ddr_rd_pkg::dl_index_t index,
   input  wire ddr_rd_pkg::dl_addr_t  ioctl_addr,
   output logic                       start,
   output ddr_rd_pkg::dl_addr_t       length
);

   logic download_q;
   logic cfg_end;

   // Falling edge of download with a configuration index
   assign cfg_end = download_q & ~download & (index[5:0] == 6'(`MSX_CFG_INDEX));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         download_q <= 1'b0;
         start      <= 1'b0;
      end else begin
         download_q <= download;
         start      <= cfg_end;   // Single cycle pulse
      end
   end

   // Last address of the image, held until the next configuration download ends
   always_ff @(posedge clk) begin
      if (cfg_end) begin
         length <= ioctl_addr;
      end
   end

endmodule

`default_nettype wire

// File: logic/msx_cfg_macros.svh
`ifndef MSX_CFG_MACROS_SVH
`define MSX_CFG_MACROS_SVH

// Entries in the machine configuration table
`define MSX_MAX_CONFIG 16

// Every ROM block starts with a header of this many bytes
`define MSX_HEADER_BYTES 16

// ROM blocks are 16 KiB
`define MSX_BLOCK_SHIFT 14

// Download index of a configuration image
`define MSX_CFG_INDEX 1

`endif

// File: logic/msx_cfg_pkg.sv
`default_nettype none

package msx_cfg_pkg;

   typedef enum logic [7:0] {
      CONFIG_NONE = 8'd0,
      CONFIG_ROM  = 8'd1,
      CONFIG_RAM  = 8'd2
   } config_typ_t;

   typedef logic [1:0] msx_type_t;
   typedef logic [3:0] block_id_t;
   typedef logic [7:0] block_count_t;   // In 16 KiB blocks
   typedef logic [1:0] slot_t;

   // One table entry, taken from bytes 4 to 7 of a block header
   typedef struct packed {
      config_typ_t           typ;
      block_id_t             block_id;
      block_count_t          block_count;
      slot_t                 slot;
      logic                  slot_internal_mapper;
      slot_t                 sub_slot;
      slot_t                 start_block;
      ddr_rd_pkg::ddr_addr_t store_address;   // First data byte after the header
   } msx_config_t;

endpackage

`default_nettype wire

// File: logic/msx_config_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "msx_cfg_macros.svh"

module msx_config_loader (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  wire logic                   ioctl_download,
   input  wire ddr_rd_pkg::dl_index_t  ioctl_index,
   input  wire ddr_rd_pkg::dl_addr_t   ioctl_addr,
   input  wire logic                   ddr3_ready,
   input  wire ddr_rd_pkg::ddr_byte_t  ddr3_dout,
   output ddr_rd_pkg::ddr_addr_t       ddr3_addr,
   output logic                        ddr3_rd,
   output logic                        ddr3_request,
   input  wire logic                   update_ack,
   output logic                        update_request,
   output msx_cfg_pkg::msx_type_t      msx_type,
   output msx_cfg_pkg::msx_config_t    msx_config [`MSX_MAX_CONFIG]
);

   logic                 cfg_start;
   ddr_rd_pkg::dl_addr_t cfg_length;

   ddr_rd_if ddr_rd ();

   assign ddr_rd.ready = ddr3_ready;
   assign ddr_rd.dout  = ddr3_dout;
   assign ddr3_addr    = ddr_rd.addr;
   assign ddr3_rd      = ddr_rd.rd;
   assign ddr3_request = ddr_rd.request;

   download_watch watch0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .download   (ioctl_download),
      .index      (ioctl_index),
      .ioctl_addr (ioctl_addr),
      .start      (cfg_start),
      .length     (cfg_length)
   );

   config_parser parser0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .start          (cfg_start),
      .length         (cfg_length),
      .mem            (ddr_rd.reader),
      .update_ack     (update_ack),
      .update_request (update_request),
      .msx_type       (msx_type),
      .msx_config     (msx_config)
   );

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/ddr_rd_pkg.sv
logic/msx_cfg_pkg.sv
logic/ddr_rd_if.sv
logic/download_watch.sv
logic/config_parser.sv
logic/msx_config_loader.sv
test/tb_ddr_model.sv
test/loader_checker.sv
test/tb_msx_config_loader.sv

// File: test/loader_checker.sv
`timescale 1ns/1ns
`default_nettype none

module loader_checker (
   input wire logic                  clk,
   input wire logic                  arst_n,
   input wire logic                  ddr3_rd,
   input wire logic                  ddr3_ready,
   input wire logic                  ddr3_request,
   input wire ddr_rd_pkg::ddr_addr_t ddr3_addr,
   input wire logic                  update_ack,
   input wire logic                  update_request
);

   int error_count = 0;

   // Address held from the strobe until the byte comes back
   addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (ddr3_rd || !ddr3_ready) |=> $stable(ddr3_addr))
      else begin
         error_count++;
         $error("ddr3_addr changed while a read was pending");
      end

   rd_in_request: assert property (@(posedge clk) disable iff (!arst_n)
      ddr3_rd |-> ddr3_request)
      else begin
         error_count++;
         $error("ddr3_rd high outside of ddr3_request");
      end

   update_held: assert property (@(posedge clk) disable iff (!arst_n)
      (update_request && !update_ack) |=> update_request)
      else begin
         error_count++;
         $error("update_request fell without update_ack");
      end

   update_release: assert property (@(posedge clk) disable iff (!arst_n)
      (update_request && update_ack) |=> !update_request)
      else begin
         error_count++;
         $error("update_request still high the cycle after update_ack");
      end

endmodule

`default_nettype wire

// File: test/tb_ddr_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ddr_model (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire logic                  rd,
   input  wire ddr_rd_pkg::ddr_addr_t addr,
   output logic                       ready,
   output ddr_rd_pkg::ddr_byte_t      dout
);

   ddr_rd_pkg::ddr_byte_t mem [ddr_rd_pkg::ddr_addr_t];   // Sparse, only headers are written
   ddr_rd_pkg::ddr_addr_t rd_log [$];                     // Accepted read addresses
   int                    max_latency = 1;

   function automatic ddr_rd_pkg::ddr_byte_t peek(input ddr_rd_pkg::ddr_addr_t a);
      if (mem.exists(a)) return mem[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ {4'h0, a[27:24]} ^ 8'h5a;   // Fill of unwritten bytes
   endfunction

   task automatic write_byte(input ddr_rd_pkg::ddr_addr_t a, input ddr_rd_pkg::ddr_byte_t b);
      mem[a] = b;
   endtask

   task automatic clear_mem();
      mem.delete();
   endtask

   task automatic clear_log();
      rd_log.delete();
   endtask

   initial begin
      ddr_rd_pkg::ddr_addr_t acc_addr;
      int                    lat;
      ready = 1'b1;
      dout  = '0;
      forever begin
         @(posedge clk);
         if (arst_n && rd && ready) begin
            acc_addr = addr;
            lat      = $urandom_range(max_latency, 1);
            rd_log.push_back(acc_addr);
            #1 ready = 1'b0;
            repeat (lat) @(posedge clk);
            #1;
            dout  = peek(acc_addr);
            ready = 1'b1;   // Byte valid from here on
         end
      end
   end

endmodule

`default_nettype wire

// File: test/tb_msx_config_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "msx_cfg_macros.svh"

module tb_msx_config_loader;

   localparam int PARSE_TIMEOUT = 20000;
   localparam int IDLE_WINDOW   = 300;

   logic                     clk;
   logic                     arst_n;
   logic                     ioctl_download;
   ddr_rd_pkg::dl_index_t    ioctl_index;
   ddr_rd_pkg::dl_addr_t     ioctl_addr;
   logic                     ddr3_ready;
   ddr_rd_pkg::ddr_byte_t    ddr3_dout;
   ddr_rd_pkg::ddr_addr_t    ddr3_addr;
   logic                     ddr3_rd;
   logic                     ddr3_request;
   logic                     update_ack;
   logic                     update_request;
   msx_cfg_pkg::msx_type_t   msx_type;
   msx_cfg_pkg::msx_config_t msx_config [`MSX_MAX_CONFIG];

   msx_cfg_pkg::msx_config_t exp_cfg [`MSX_MAX_CONFIG];
   msx_cfg_pkg::msx_type_t   exp_type;
   ddr_rd_pkg::ddr_addr_t    exp_reads [$];
   int                       blk_off [`MSX_MAX_CONFIG];
   int                       image_end;

   msx_config_loader dut0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .ddr3_ready     (ddr3_ready),
      .ddr3_dout      (ddr3_dout),
      .ddr3_addr      (ddr3_addr),
      .ddr3_rd        (ddr3_rd),
      .ddr3_request   (ddr3_request),
      .update_ack     (update_ack),
      .update_request (update_request),
      .msx_type       (msx_type),
      .msx_config     (msx_config)
   );

   tb_ddr_model mem0 (
      .clk    (clk),
      .arst_n (arst_n),
      .rd     (ddr3_rd),
      .addr   (ddr3_addr),
      .ready  (ddr3_ready),
      .dout   (ddr3_dout)
   );

   bind msx_config_loader loader_checker checks0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .ddr3_rd        (ddr3_rd),
      .ddr3_ready     (ddr3_ready),
      .ddr3_request   (ddr3_request),
      .ddr3_addr      (ddr3_addr),
      .update_ack     (update_ack),
      .update_request (update_request)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   always @(negedge clk) begin
      if (dut0.checks0.error_count != 0) report_failure("A bound protocol assertion failed");
   end

   task automatic check_config(input int idx, input msx_cfg_pkg::msx_config_t got,
                               input msx_cfg_pkg::msx_config_t exp);
      // Empty entries keep stale fields, only the type is defined
      if (exp.typ == msx_cfg_pkg::CONFIG_NONE ? got.typ !== exp.typ : got !== exp)
         report_failure($sformatf("Mismatch msx_config[%0d]: got %h expected %h", idx, got, exp));
   endtask

   task automatic check_type(input msx_cfg_pkg::msx_type_t got, input msx_cfg_pkg::msx_type_t exp);
      if (got !== exp) report_failure($sformatf("Mismatch msx_type: got %h expected %h", got, exp));
   endtask

   task automatic check_addr(input int idx, input ddr_rd_pkg::ddr_addr_t got,
                             input ddr_rd_pkg::ddr_addr_t exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch ddr3_addr read %0d: got %h expected %h", idx, got, exp));
   endtask

   function automatic ddr_rd_pkg::ddr_byte_t magic_byte(input int j);
      case (j)
         0:       return "M";
         1:       return "S";
         default: return "X";
      endcase
   endfunction

   task automatic build_image(input int n);
      int                    off;
      ddr_rd_pkg::ddr_byte_t typ;
      ddr_rd_pkg::ddr_byte_t cnt;
      ddr_rd_pkg::ddr_byte_t hb;
      mem0.clear_mem();
      off = 0;
      for (int b = 0; b < n; b++) begin
         typ = ($urandom_range(1, 0) != 0) ? 8'(msx_cfg_pkg::CONFIG_RAM) : 8'(msx_cfg_pkg::CONFIG_ROM);
         cnt = 8'($urandom_range(15, 0));   // Keeps the image inside 24 bits of offset
         blk_off[b] = off;
         for (int j = 0; j < `MSX_HEADER_BYTES; j++) begin
            case (j)
               0, 1, 2: hb = magic_byte(j);
               4:       hb = typ;
               6:       hb = cnt;
               default: hb = 8'($urandom);
            endcase
            mem0.write_byte(ddr_rd_pkg::ddr_addr_t'(off + j), hb);
         end
         off = off + `MSX_HEADER_BYTES
               + ((typ == 8'(msx_cfg_pkg::CONFIG_RAM)) ? 0 : (int'(cnt) << `MSX_BLOCK_SHIFT));
      end
      image_end = off;
   endtask

   // Reference walk over the headers, also yields the expected read order
   task automatic predict_table(input int len);
      int                    off;
      int                    a;
      bit                    done;
      bit                    valid;
      ddr_rd_pkg::ddr_byte_t b;
      exp_reads.delete();
      off = 0;
      for (int e = 0; e < `MSX_MAX_CONFIG; e++) begin
         valid = 1'b0;
         done  = (off > len);
         for (int j = 0; j < 8 && !done; j++) begin
            a = off + j;
            exp_reads.push_back(ddr_rd_pkg::ddr_addr_t'(a));
            b = mem0.peek(ddr_rd_pkg::ddr_addr_t'(a));
            if (j < 3 && b != magic_byte(j)) begin
               done = 1'b1;
            end else begin
               case (j)
                  3: if (e == 0) exp_type = b[1:0];
                  4: exp_cfg[e].typ = msx_cfg_pkg::config_typ_t'(b);
                  5: exp_cfg[e].block_id = b[3:0];
                  6: exp_cfg[e].block_count = b;
                  7: begin
                     exp_cfg[e].slot                 = b[6:5];
                     exp_cfg[e].slot_internal_mapper = b[4];
                     exp_cfg[e].sub_slot             = b[3:2];
                     exp_cfg[e].start_block          = b[1:0];
                     exp_cfg[e].store_address        = ddr_rd_pkg::ddr_addr_t'(off + 16);
                  end
                  default: ;
               endcase
               valid = (j == 7);
               done  = valid || (off + j + 1 > len);
            end
         end
         if (valid) begin
            off = off + `MSX_HEADER_BYTES
                  + ((exp_cfg[e].typ == msx_cfg_pkg::CONFIG_RAM) ? 0
                     : (int'(exp_cfg[e].block_count) << `MSX_BLOCK_SHIFT));
         end else begin
            exp_cfg[e].typ = msx_cfg_pkg::CONFIG_NONE;   // Offset stays, later entries fail too
         end
      end
   endtask

   task automatic compare_table();
      for (int i = 0; i < `MSX_MAX_CONFIG; i++) check_config(i, msx_config[i], exp_cfg[i]);
      check_type(msx_type, exp_type);
   endtask

   task automatic compare_reads();
      if (mem0.rd_log.size() != exp_reads.size())
         report_failure($sformatf("Mismatch ddr3_rd count: got %h expected %h",
                                  mem0.rd_log.size(), exp_reads.size()));
      for (int i = 0; i < exp_reads.size(); i++) check_addr(i, mem0.rd_log[i], exp_reads[i]);
   endtask

   task automatic run_download(input ddr_rd_pkg::dl_index_t idx, input int len);
      @(posedge clk);
      #1;
      ioctl_index    = idx;
      ioctl_addr     = ddr_rd_pkg::dl_addr_t'(len);   // Last address of the image
      ioctl_download = 1'b1;
      repeat (3) @(posedge clk);
      #1 ioctl_download = 1'b0;
   endtask

   task automatic wait_update();
      int n;
      n = 0;
      while (update_request !== 1'b1) begin
         if (n == PARSE_TIMEOUT) report_failure("Timeout waiting for update_request after a download");
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   task automatic ack_update();
      int delay;
      delay = $urandom_range(12, 0);
      repeat (delay) begin
         @(posedge clk);
         #1;
         if (update_request !== 1'b1) report_failure("update_request fell before update_ack");
      end
      update_ack = 1'b1;
      @(posedge clk);
      #1;
      update_ack = 1'b0;
      if (update_request !== 1'b0) report_failure("update_request stayed high after update_ack");
   endtask

   task automatic run_parse(input int len);
      mem0.clear_log();
      predict_table(len);
      run_download(16'(`MSX_CFG_INDEX), len);
      wait_update();
      if (ddr3_request !== 1'b0) report_failure("ddr3_request still high after the parse ended");
      compare_reads();
      compare_table();
      ack_update();
   endtask

   task automatic run_ignored(input ddr_rd_pkg::dl_index_t idx, input int len);
      mem0.clear_log();
      run_download(idx, len);
      repeat (IDLE_WINDOW) begin
         @(posedge clk);
         #1;
         if (ddr3_request !== 1'b0 || update_request !== 1'b0)
            report_failure("Parser started after a download with another index");
      end
      if (mem0.rd_log.size() != 0) report_failure("Memory was read after a download with another index");
      compare_table();
   endtask

   initial begin
      int k;
      int n;
      void'($urandom(25529));
      arst_n         = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      update_ack     = 1'b0;
      exp_type       = '0;
      for (int i = 0; i < `MSX_MAX_CONFIG; i++) exp_cfg[i] = '0;
      repeat (10) @(posedge clk);
      #1 arst_n = 1'b1;
      compare_table();

      mem0.max_latency = 1;
      build_image($urandom_range(`MSX_MAX_CONFIG, 1));
      run_parse(image_end - 1);
      mem0.max_latency = 8;   // Same image, same expected table
      run_parse(image_end - 1);
      build_image(`MSX_MAX_CONFIG);
      run_parse(image_end - 1);

      n = $urandom_range(`MSX_MAX_CONFIG, 2);   // Broken magic in block k
      build_image(n);
      k = $urandom_range(n - 1, 0);
      begin
         int j;
         j = $urandom_range(2, 0);
         mem0.write_byte(ddr_rd_pkg::ddr_addr_t'(blk_off[k] + j),
                         magic_byte(j) ^ 8'($urandom_range(255, 1)));
      end
      run_parse(image_end - 1);

      n = $urandom_range(`MSX_MAX_CONFIG, 1);   // Image ends inside header k
      build_image(n);
      k = $urandom_range(n - 1, 0);
      run_parse(blk_off[k] + $urandom_range(6, 0));

      build_image($urandom_range(`MSX_MAX_CONFIG, 1));
      run_ignored({10'($urandom), 6'($urandom_range(63, 2))}, image_end - 1);

      if (dut0.checks0.error_count != 0) begin
         report_failure("A bound protocol assertion failed");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

`default_nettype wire
